// File: usb_xact.f
+incdir+hw
hw/usb_xact_pkg.sv
hw/usb_proto_timer.sv
hw/usb_token_select.sv
hw/usb_xact_fsm.sv
hw/usb_xact_response.sv
hw/usb_xact_top.sv
verif/usb_xact_chk.sv
verif/usb_xact_tb.sv

// File: verif/usb_xact_patterns.txt
// tok_pid addr endp flags(set,clr,halt,rdy) data_pid parity outcome exp_pid exp_sel strobe
// outcome 0 silent, 1 handshake, 2 DATAx and host ACK, 3 timeout, 4 DATAx then timeout
// exp_sel 0 none, 1 bulk OUT, 2 bulk IN; strobe 0 none, 1 out_fin, 2 out_can, 3 in_fin, 4 in_can
D_05_0_0_3_0_1_2_0_0
9_05_2_1_0_0_3_0_0_0
1_05_1_9_3_0_1_2_1_1
1_05_1_1_B_1_1_2_1_1
1_05_1_1_B_0_0_0_1_0
1_05_1_0_3_0_1_A_1_0
4_05_1_1_0_0_1_2_1_0
4_05_1_0_0_0_1_A_1_0
9_05_2_1_0_0_2_3_2_3
9_05_2_1_0_1_2_B_2_3
9_05_2_0_0_0_1_A_2_0
9_05_2_1_0_0_4_3_2_4
1_05_1_1_0_0_3_0_1_2
9_06_2_1_0_0_0_0_0_0
1_05_1_3_0_0_3_0_0_0
9_05_2_3_0_0_3_0_0_0
D_05_0_2_B_1_1_2_0_0
1_05_1_9_3_0_1_2_1_1
1_05_1_5_0_0_3_0_0_0
1_00_1_9_0_0_0_0_0_0

// File: verif/usb_xact_tb.sv
`timescale 1ns/1ps
`include "usb_xact_config.svh"

module usb_xact_tb import usb_xact_pkg::*; ();

  localparam int SIG_HSK = 0;
  localparam int SIG_MUX = 1;
  localparam int SIG_TMO = 2;

  logic clock = 1'b0;
  logic reset;
  logic tok_recv_i, usb_recv_i, rx_sop_i, eop_recv_i, crc_error_i, dec_actv_i;
  logic hsk_recv_i, hsk_sent_i, usb_busy_i, usb_sent_i, set_conf_i, clr_conf_i;
  logic ep0_parity_i, out_rx_rdy_i, out_parity_i, out_halted_i;
  logic in_tx_rdy_i, in_parity_i, in_halted_i;
  pid_t tok_pid_i;
  pid_t data_pid_i;
  logic [`USB_ADDR_W-1:0] tok_addr_i;
  logic [`USB_ADDR_W-1:0] usb_addr_i;
  logic [3:0] tok_endp_i;
  logic hsk_send_o, mux_enable_o, timedout_o;
  logic out_select_o, out_finish_o, out_cancel_o;
  logic in_select_o, in_finish_o, in_cancel_o;
  pid_t tuser_pid_o;
  ep_idx_t mux_select_o;

  logic [43:0] patterns [0:31];
  string test_name;
  int hsk_cnt, tmo_cnt, out_fin_cnt, out_can_cnt, in_fin_cnt, in_can_cnt;
  logic hsk_prev;

  usb_xact_top DUT (.*);

  always #50 clock = ~clock;

  // Event counters cleared at the start of each pattern
  always @(posedge clock) begin
    hsk_prev <= hsk_send_o;
    if (hsk_send_o && !hsk_prev) hsk_cnt++;
    if (timedout_o) tmo_cnt++;
    if (out_finish_o) out_fin_cnt++;
    if (out_cancel_o) out_can_cnt++;
    if (in_finish_o) in_fin_cnt++;
    if (in_cancel_o) in_can_cnt++;
  end

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("** Error %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
      $display(">>> FAIL");
      $fatal(1);
    end
  endtask

  function automatic logic probe(input int which);
    case (which)
      SIG_HSK: return hsk_send_o;
      SIG_MUX: return mux_enable_o;
      default: return timedout_o;
    endcase
  endfunction

  task automatic wait_for(input int which, input int limit, input string what);
    int n;
    n = 0;
    while (probe(which) !== 1'b1) begin
      if (n == limit) begin
        $display("Timeout in %s while waiting for %s", test_name, what);
        $display(">>> FAIL");
        $fatal(1);
      end
      n++;
      @(negedge clock);
    end
  endtask

  // Host side of a DATAx packet
  task automatic send_data(input logic [3:0] dpid);
    // Inter-packet gap after the token
    @(negedge clock);
    data_pid_i = pid_t'(dpid);
    rx_sop_i   = 1'b1;
    dec_actv_i = 1'b1;
    @(negedge clock);
    rx_sop_i = 1'b0;
    repeat (2) @(negedge clock);
    usb_recv_i = 1'b1;
    @(negedge clock);
    usb_recv_i = 1'b0;
    eop_recv_i = 1'b1;
    @(negedge clock);
    eop_recv_i = 1'b0;
    dec_actv_i = 1'b0;
  endtask

  // Encoder side of a DATAx packet from the IN endpoint
  task automatic send_in_data(input logic [3:0] epid);
    wait_for(SIG_MUX, 60, "mux enable");
    check_value("mux select", 32'd2, mux_select_o);
    check_value("data pid", epid, tuser_pid_o);
    usb_busy_i = 1'b1;
    repeat (3) @(negedge clock);
    usb_sent_i = 1'b1;
    @(negedge clock);
    usb_sent_i = 1'b0;
    usb_busy_i = 1'b0;
  endtask

  task automatic pulse_hsk_recv();
    hsk_recv_i = 1'b1;
    @(negedge clock);
    hsk_recv_i = 1'b0;
  endtask

  task automatic run_pattern(input logic [43:0] p);
    logic [3:0] flags;
    logic [3:0] dpid;
    logic [3:0] outc;
    logic [3:0] epid;
    logic [3:0] estr;
    flags = p[27:24];
    dpid  = p[23:20];
    outc  = p[15:12];
    epid  = p[11:8];
    estr  = p[3:0];
    hsk_cnt = 0;
    tmo_cnt = 0;
    out_fin_cnt = 0;
    out_can_cnt = 0;
    in_fin_cnt = 0;
    in_can_cnt = 0;
    @(negedge clock);
    set_conf_i   = flags[3];
    clr_conf_i   = flags[2];
    out_halted_i = flags[1];
    in_halted_i  = flags[1];
    out_rx_rdy_i = flags[0];
    in_tx_rdy_i  = flags[0];
    ep0_parity_i = p[16];
    out_parity_i = p[16];
    in_parity_i  = p[16];
    @(negedge clock);
    set_conf_i = 1'b0;
    clr_conf_i = 1'b0;
    repeat (2) @(negedge clock);
    tok_pid_i  = pid_t'(p[43:40]);
    tok_addr_i = p[38:32];
    tok_endp_i = p[31:28];
    tok_recv_i = 1'b1;
    @(negedge clock);
    tok_recv_i = 1'b0;
    check_value("select", p[7:4], {in_select_o, out_select_o});
    if (dpid != 4'd0) send_data(dpid);
    case (outc)
      4'd1: begin
        wait_for(SIG_HSK, 60, "handshake");
        check_value("handshake pid", epid, tuser_pid_o);
        hsk_sent_i = 1'b1;
        @(negedge clock);
        hsk_sent_i = 1'b0;
        check_value("handshake end", 32'd0, hsk_send_o);
      end
      4'd2: begin
        send_in_data(epid);
        @(negedge clock);
        pulse_hsk_recv();
      end
      4'd3: wait_for(SIG_TMO, 250, "timeout");
      4'd4: begin
        send_in_data(epid);
        wait_for(SIG_TMO, 250, "timeout");
      end
      default: ;
    endcase
    // Let every protocol timer run out before counting
    repeat (130) @(negedge clock);
    check_value("handshakes", outc == 4'd1, hsk_cnt);
    if (outc != 4'd1) begin
      check_value("timeouts", outc >= 4'd3, tmo_cnt);
    end
    check_value("out finish", estr == 4'd1, out_fin_cnt);
    check_value("out cancel", estr == 4'd2, out_can_cnt);
    check_value("in finish", estr == 4'd3, in_fin_cnt);
    check_value("in cancel", estr == 4'd4, in_can_cnt);
  endtask

  initial begin
    int i;
    reset = 1'b1;
    tok_recv_i = 1'b0;
    usb_recv_i = 1'b0;
    rx_sop_i = 1'b0;
    eop_recv_i = 1'b0;
    crc_error_i = 1'b0;
    dec_actv_i = 1'b0;
    hsk_recv_i = 1'b0;
    hsk_sent_i = 1'b0;
    usb_busy_i = 1'b0;
    usb_sent_i = 1'b0;
    set_conf_i = 1'b0;
    clr_conf_i = 1'b0;
    ep0_parity_i = 1'b0;
    out_rx_rdy_i = 1'b0;
    out_parity_i = 1'b0;
    out_halted_i = 1'b0;
    in_tx_rdy_i = 1'b0;
    in_parity_i = 1'b0;
    in_halted_i = 1'b0;
    tok_pid_i = PID_OUT;
    data_pid_i = PID_DATA0;
    tok_addr_i = '0;
    tok_endp_i = 4'd0;
    usb_addr_i = 7'h05;
    test_name = "reset";
    $readmemh("verif/usb_xact_patterns.txt", patterns);
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    check_value("state after reset", 32'd0, {hsk_send_o, mux_enable_o, timedout_o});
    i = 0;
    while (i < 32 && !$isunknown(patterns[i])) begin
      test_name = $sformatf("pattern %0d", i);
      run_pattern(patterns[i]);
      i++;
    end
    if (i == 0) begin
      $display("No patterns were read from the pattern file");
      $display(">>> FAIL");
      $fatal(1);
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

// File: verif/usb_xact_chk.sv
`timescale 1ns/1ps

module usb_xact_chk (
  input logic clock,
  input logic reset,
  input logic hsk_send_i,
  input logic mux_enable_i,
  input logic ep0_sel_i,
  input logic out_sel_i,
  input logic in_sel_i,
  input logic timedout_i
);

  // Handshake and endpoint data never share the encoder
  property hsk_mux_exclusive;
    @(posedge clock) disable iff (reset) !(hsk_send_i && mux_enable_i);
  endproperty

  property single_select;
    @(posedge clock) disable iff (reset) $onehot0({ep0_sel_i, out_sel_i, in_sel_i});
  endproperty

  property no_timeout_after_reset;
    @(posedge clock) $fell(reset) |-> !timedout_i;
  endproperty

  a_hsk_mux: assert property (hsk_mux_exclusive)
    else $error("handshake and data multiplexer enabled together");

  a_select: assert property (single_select)
    else $error("more than one endpoint selected");

  a_reset_timeout: assert property (no_timeout_after_reset)
    else $error("timeout flag high right after reset");

endmodule

bind usb_xact_top usb_xact_chk u_chk (
  .clock        (clock),
  .reset        (reset),
  .hsk_send_i   (hsk_send_o),
  .mux_enable_i (mux_enable_o),
  .ep0_sel_i    (ep0_sel),
  .out_sel_i    (out_sel),
  .in_sel_i     (in_sel),
  .timedout_i   (timedout_o)
);

// File: hw/usb_xact_top.sv
`timescale 1ns/1ps
`include "usb_xact_config.svh"

module usb_xact_top
  import usb_xact_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   tok_recv_i,
  input  pid_t                   tok_pid_i,
  input  logic [`USB_ADDR_W-1:0] tok_addr_i,
  input  logic [3:0]             tok_endp_i,
  input  logic                   usb_recv_i,
  input  pid_t                   data_pid_i,
  input  logic                   rx_sop_i,
  input  logic                   eop_recv_i,
  input  logic                   crc_error_i,
  input  logic                   dec_actv_i,
  input  logic                   hsk_recv_i,
  input  logic                   hsk_sent_i,
  input  logic                   usb_busy_i,
  input  logic                   usb_sent_i,
  input  logic                   set_conf_i,
  input  logic                   clr_conf_i,
  input  logic [`USB_ADDR_W-1:0] usb_addr_i,
  input  logic                   ep0_parity_i,
  input  logic                   out_rx_rdy_i,
  input  logic                   out_parity_i,
  input  logic                   out_halted_i,
  input  logic                   in_tx_rdy_i,
  input  logic                   in_parity_i,
  input  logic                   in_halted_i,
  output logic                   hsk_send_o,
  output pid_t                   tuser_pid_o,
  output logic                   mux_enable_o,
  output ep_idx_t                mux_select_o,
  output logic                   timedout_o,
  output logic                   out_select_o,
  output logic                   out_finish_o,
  output logic                   out_cancel_o,
  output logic                   in_select_o,
  output logic                   in_finish_o,
  output logic                   in_cancel_o
);

  logic        tok_hit;
  pid_t        tok_pid_q;
  logic [3:0]  tok_endp_q;
  logic        ep0_sel;
  logic        out_sel;
  logic        in_sel;
  logic        out_rdy;
  logic        in_rdy;
  logic        par_ok;
  xact_state_t state;
  logic        xact_end;
  logic        in_tok;
  logic        out_tok;
  logic        ta_start;
  logic        ta_expired;
  logic        ep_expired;
  logic        td_expired;
  logic        timeout_q;

  assign hsk_send_o   = state == ST_RESP;
  assign timedout_o   = timeout_q;
  assign out_select_o = out_sel;
  assign in_select_o  = in_sel;

  usb_token_select u_select (
    .clock        (clock),
    .reset        (reset),
    .tok_recv_i   (tok_recv_i),
    .tok_pid_i    (tok_pid_i),
    .tok_addr_i   (tok_addr_i),
    .tok_endp_i   (tok_endp_i),
    .usb_addr_i   (usb_addr_i),
    .set_conf_i   (set_conf_i),
    .clr_conf_i   (clr_conf_i),
    .dec_actv_i   (dec_actv_i),
    .data_pid_i   (data_pid_i),
    .xact_end_i   (xact_end),
    .out_rx_rdy_i (out_rx_rdy_i),
    .out_halted_i (out_halted_i),
    .out_parity_i (out_parity_i),
    .in_tx_rdy_i  (in_tx_rdy_i),
    .in_halted_i  (in_halted_i),
    .ep0_parity_i (ep0_parity_i),
    .tok_hit_o    (tok_hit),
    .tok_pid_o    (tok_pid_q),
    .tok_endp_o   (tok_endp_q),
    .ep0_sel_o    (ep0_sel),
    .out_sel_o    (out_sel),
    .in_sel_o     (in_sel),
    .out_rdy_o    (out_rdy),
    .in_rdy_o     (in_rdy),
    .par_ok_o     (par_ok)
  );

  usb_xact_fsm u_fsm (
    .clock        (clock),
    .reset        (reset),
    .tok_hit_i    (tok_hit),
    .tok_pid_i    (tok_pid_q),
    .ep0_sel_i    (ep0_sel),
    .out_sel_i    (out_sel),
    .in_sel_i     (in_sel),
    .out_rdy_i    (out_rdy),
    .in_rdy_i     (in_rdy),
    .par_ok_i     (par_ok),
    .usb_recv_i   (usb_recv_i),
    .usb_sent_i   (usb_sent_i),
    .eop_recv_i   (eop_recv_i),
    .hsk_sent_i   (hsk_sent_i),
    .hsk_recv_i   (hsk_recv_i),
    .crc_error_i  (crc_error_i),
    .clr_conf_i   (clr_conf_i),
    .timeout_i    (timeout_q),
    .state_o      (state),
    .xact_end_o   (xact_end),
    .in_tok_o     (in_tok),
    .out_tok_o    (out_tok),
    .ta_start_o   (ta_start),
    .out_finish_o (out_finish_o),
    .out_cancel_o (out_cancel_o),
    .in_finish_o  (in_finish_o),
    .in_cancel_o  (in_cancel_o)
  );

  usb_xact_response u_response (
    .clock        (clock),
    .reset        (reset),
    .state_i      (state),
    .tok_hit_i    (tok_hit),
    .tok_pid_i    (tok_pid_q),
    .tok_endp_i   (tok_endp_q),
    .ep0_sel_i    (ep0_sel),
    .out_rdy_i    (out_rdy),
    .usb_busy_i   (usb_busy_i),
    .ep0_parity_i (ep0_parity_i),
    .in_parity_i  (in_parity_i),
    .in_sel_i     (in_sel),
    .pid_o        (tuser_pid_o),
    .mux_enable_o (mux_enable_o),
    .mux_select_o (mux_select_o)
  );

  // Host handshake after our DATAx
  usb_proto_timer #(.MAX_COUNT(`USB_TA_CYCLES)) u_ta_timer (
    .clock     (clock),
    .reset     (reset),
    .start_i   (ta_start),
    .event_i   (hsk_recv_i),
    .expired_o (ta_expired)
  );

  // Endpoint starts sending after IN
  usb_proto_timer #(.MAX_COUNT(`USB_EP_CYCLES)) u_ep_timer (
    .clock     (clock),
    .reset     (reset),
    .start_i   (in_tok),
    .event_i   (usb_busy_i),
    .expired_o (ep_expired)
  );

  // Host DATAx after OUT or SETUP
  usb_proto_timer #(.MAX_COUNT(`USB_TD_CYCLES)) u_td_timer (
    .clock     (clock),
    .reset     (reset),
    .start_i   (out_tok),
    .event_i   (rx_sop_i),
    .expired_o (td_expired)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      timeout_q <= 1'b0;
    end else begin
      timeout_q <= ta_expired || ep_expired || td_expired;
    end
  end

endmodule

// File: hw/usb_xact_response.sv
`timescale 1ns/1ps
`include "usb_xact_config.svh"

module usb_xact_response
  import usb_xact_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  xact_state_t state_i,
  input  logic        tok_hit_i,
  input  pid_t        tok_pid_i,
  input  logic [3:0]  tok_endp_i,
  input  logic        ep0_sel_i,
  input  logic        out_rdy_i,
  input  logic        usb_busy_i,
  input  logic        ep0_parity_i,
  input  logic        in_parity_i,
  input  logic        in_sel_i,
  output pid_t        pid_o,
  output logic        mux_enable_o,
  output ep_idx_t     mux_select_o
);

  logic seq_q;

  // Sequence bit of the sending endpoint, frozen while the encoder is busy
  always_ff @(posedge clock) begin
    if (!usb_busy_i) begin
      seq_q <= (ep0_sel_i && ep0_parity_i) || (in_sel_i && in_parity_i);
    end
  end

  always_ff @(posedge clock) begin
    case (state_i)
      ST_IDLE: begin
        if (tok_hit_i && tok_pid_i == PID_IN) begin
          pid_o <= PID_NAK;
        end else if (tok_hit_i && tok_pid_i == PID_PING) begin
          pid_o <= (ep0_sel_i || out_rdy_i) ? PID_ACK : PID_NAK;
        end
      end
      ST_RECV: pid_o <= PID_ACK;
      ST_DROP: pid_o <= PID_NAK;
      ST_SEND: pid_o <= seq_q ? PID_DATA1 : PID_DATA0;
      default: pid_o <= pid_o;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mux_enable_o <= 1'b0;
      mux_select_o <= EP_IDX_NONE;
    end else begin
      mux_enable_o <= state_i == ST_SEND || state_i == ST_WAIT;
      case (tok_endp_i)
        4'd0:             mux_select_o <= EP_IDX_CTRL;
        `USB_BULK_OUT_EP: mux_select_o <= EP_IDX_OUT;
        `USB_BULK_IN_EP:  mux_select_o <= EP_IDX_IN;
        default:          mux_select_o <= EP_IDX_NONE;
      endcase
    end
  end

endmodule

// File: hw/usb_xact_fsm.sv
`timescale 1ns/1ps

module usb_xact_fsm
  import usb_xact_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        tok_hit_i,
  input  pid_t        tok_pid_i,
  input  logic        ep0_sel_i,
  input  logic        out_sel_i,
  input  logic        in_sel_i,
  input  logic        out_rdy_i,
  input  logic        in_rdy_i,
  input  logic        par_ok_i,
  input  logic        usb_recv_i,
  input  logic        usb_sent_i,
  input  logic        eop_recv_i,
  input  logic        hsk_sent_i,
  input  logic        hsk_recv_i,
  input  logic        crc_error_i,
  input  logic        clr_conf_i,
  input  logic        timeout_i,
  output xact_state_t state_o,
  output logic        xact_end_o,
  output logic        in_tok_o,
  output logic        out_tok_o,
  output logic        ta_start_o,
  output logic        out_finish_o,
  output logic        out_cancel_o,
  output logic        in_finish_o,
  output logic        in_cancel_o
);

  xact_state_t state_q;
  logic        crc_seen_q;
  logic        crc_err_q;
  logic        rx_ok_q;
  logic        new_tok;

  assign state_o    = state_q;
  assign new_tok    = state_q == ST_IDLE && tok_hit_i;
  assign in_tok_o   = new_tok && tok_pid_i == PID_IN;
  assign out_tok_o  = new_tok && (tok_pid_i == PID_OUT || tok_pid_i == PID_SETUP);
  assign ta_start_o = state_q == ST_SEND && usb_sent_i;

  // One pulse per CRC error, however long the level stays up
  always_ff @(posedge clock) begin
    if (reset) begin
      crc_seen_q <= 1'b0;
      crc_err_q  <= 1'b0;
    end else begin
      crc_seen_q <= crc_error_i;
      crc_err_q  <= crc_error_i && !crc_seen_q;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      xact_end_o <= 1'b0;
    end else begin
      xact_end_o <= clr_conf_i || hsk_recv_i || hsk_sent_i || timeout_i || crc_err_q;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (tok_hit_i) begin
            case (tok_pid_i)
              PID_SETUP: state_q <= ep0_sel_i ? ST_RECV : ST_WAIT;
              PID_OUT: begin
                if (ep0_sel_i || out_rdy_i) begin
                  state_q <= ST_RECV;
                end else if (out_sel_i) begin
                  // No room, so discard the data and NAK
                  state_q <= ST_DROP;
                end else begin
                  state_q <= ST_WAIT;
                end
              end
              PID_IN: begin
                if (ep0_sel_i || in_rdy_i) begin
                  state_q <= ST_SEND;
                end else if (in_sel_i) begin
                  state_q <= ST_RESP;
                end else begin
                  // Unknown or halted endpoint, let the timer end it
                  state_q <= ST_WAIT;
                end
              end
              PID_PING: state_q <= ST_RESP;
              default:  state_q <= ST_IDLE;
            endcase
          end
        end
        ST_RECV: begin
          if (usb_recv_i) begin
            // Toggle mismatch means a retry, so stay silent
            state_q <= par_ok_i ? ST_RESP : ST_IDLE;
          end else if (timeout_i || crc_error_i) begin
            state_q <= ST_IDLE;
          end
        end
        ST_SEND: begin
          if (usb_sent_i) begin
            state_q <= ST_WAIT;
          end else if (timeout_i) begin
            state_q <= ST_IDLE;
          end
        end
        ST_DROP: begin
          if (eop_recv_i) begin
            state_q <= ST_RESP;
          end else if (timeout_i) begin
            state_q <= ST_IDLE;
          end
        end
        ST_RESP: begin
          if (hsk_sent_i || timeout_i) begin
            state_q <= ST_IDLE;
          end
        end
        ST_WAIT: begin
          if (hsk_recv_i || timeout_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Marks an ACK that completes received data, not a NAK or a PING reply
  always_ff @(posedge clock) begin
    if (reset || state_q == ST_IDLE) begin
      rx_ok_q <= 1'b0;
    end else if (state_q == ST_RECV && usb_recv_i && par_ok_i) begin
      rx_ok_q <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || xact_end_o) begin
      out_finish_o <= 1'b0;
      out_cancel_o <= 1'b0;
      in_finish_o  <= 1'b0;
      in_cancel_o  <= 1'b0;
    end else begin
      out_finish_o <= out_sel_i && rx_ok_q && hsk_sent_i;
      in_finish_o  <= in_sel_i && state_q == ST_WAIT && hsk_recv_i;
      out_cancel_o <= out_sel_i && (crc_err_q || timeout_i);
      in_cancel_o  <= in_sel_i && (crc_err_q || timeout_i);
    end
  end

endmodule

// File: hw/usb_token_select.sv
`timescale 1ns/1ps
`include "usb_xact_config.svh"

module usb_token_select
  import usb_xact_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   tok_recv_i,
  input  pid_t                   tok_pid_i,
  input  logic [`USB_ADDR_W-1:0] tok_addr_i,
  input  logic [3:0]             tok_endp_i,
  input  logic [`USB_ADDR_W-1:0] usb_addr_i,
  input  logic                   set_conf_i,
  input  logic                   clr_conf_i,
  input  logic                   dec_actv_i,
  input  pid_t                   data_pid_i,
  input  logic                   xact_end_i,
  input  logic                   out_rx_rdy_i,
  input  logic                   out_halted_i,
  input  logic                   out_parity_i,
  input  logic                   in_tx_rdy_i,
  input  logic                   in_halted_i,
  input  logic                   ep0_parity_i,
  output logic                   tok_hit_o,
  output pid_t                   tok_pid_o,
  output logic [3:0]             tok_endp_o,
  output logic                   ep0_sel_o,
  output logic                   out_sel_o,
  output logic                   in_sel_o,
  output logic                   out_rdy_o,
  output logic                   in_rdy_o,
  output logic                   par_ok_o
);

  logic tok_match;
  logic out_en_q;
  logic in_en_q;
  logic out_ready_q;
  logic in_ready_q;
  logic toggle;

  assign tok_match = tok_recv_i && (tok_addr_i == usb_addr_i);
  assign toggle    = data_pid_i[3];

  always_ff @(posedge clock) begin
    if (reset) begin
      tok_hit_o <= 1'b0;
    end else begin
      tok_hit_o <= tok_match;
    end
  end

  always_ff @(posedge clock) begin
    if (tok_match) begin
      tok_pid_o  <= tok_pid_i;
      tok_endp_o <= tok_endp_i;
    end
  end

  // Bulk endpoints are usable only while configured and not halted
  always_ff @(posedge clock) begin
    if (reset || clr_conf_i || out_halted_i) begin
      out_en_q <= 1'b0;
    end else if (set_conf_i) begin
      out_en_q <= 1'b1;
    end

    if (reset || clr_conf_i || in_halted_i) begin
      in_en_q <= 1'b0;
    end else if (set_conf_i) begin
      in_en_q <= 1'b1;
    end
  end

  // One select at most, held for the whole transaction
  always_ff @(posedge clock) begin
    if (reset || xact_end_i) begin
      ep0_sel_o <= 1'b0;
      out_sel_o <= 1'b0;
      in_sel_o  <= 1'b0;
    end else if (tok_match) begin
      ep0_sel_o <= tok_endp_i == 4'd0;
      out_sel_o <= out_en_q && !out_halted_i && tok_endp_i == `USB_BULK_OUT_EP &&
                   (tok_pid_i == PID_OUT || tok_pid_i == PID_PING);
      in_sel_o  <= in_en_q && !in_halted_i && tok_endp_i == `USB_BULK_IN_EP &&
                   tok_pid_i == PID_IN;
    end
  end

  always_ff @(posedge clock) begin
    out_ready_q <= out_rx_rdy_i && !out_halted_i;
    in_ready_q  <= in_tx_rdy_i && !in_halted_i;
  end

  // Readiness only counts for the selected endpoint
  assign out_rdy_o = out_sel_o && out_ready_q;
  assign in_rdy_o  = in_sel_o && in_ready_q;

  // Toggle check against the receiving endpoint's expected parity
  always_ff @(posedge clock) begin
    if (dec_actv_i) begin
      par_ok_o <= (ep0_sel_o && ep0_parity_i == toggle) ||
                  (out_sel_o && out_parity_i == toggle);
    end
  end

endmodule

// File: hw/usb_proto_timer.sv
`timescale 1ns/1ps

module usb_proto_timer #(
  parameter int MAX_COUNT = 24
) (
  input  logic clock,
  input  logic reset,
  input  logic start_i,
  input  logic event_i,
  output logic expired_o
);

  localparam int CW = $clog2(MAX_COUNT);

  logic          run_q;
  logic [CW-1:0] count_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      run_q     <= 1'b0;
      expired_o <= 1'b0;
      count_q   <= '0;
    end else begin
      expired_o <= 1'b0;
      if (start_i) begin
        run_q   <= 1'b1;
        count_q <= CW'(MAX_COUNT - 1);
      end else if (run_q) begin
        if (event_i) begin
          // Expected event arrived in time
          run_q <= 1'b0;
        end else if (count_q == '0) begin
          run_q     <= 1'b0;
          expired_o <= 1'b1;
        end else begin
          count_q <= count_q - 1'b1;
        end
      end
    end
  end

endmodule

// File: hw/usb_xact_pkg.sv
package usb_xact_pkg;

  // USB packet identifiers, in the four-bit form without the check nibble
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SOF   = 4'b0101,
    PID_SETUP = 4'b1101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010,
    PID_STALL = 4'b1110,
    PID_PING  = 4'b0100
  } pid_t;

  // Transaction states
  typedef enum logic [2:0] {
    ST_IDLE,
    // Receiving DATAx from the host
    ST_RECV,
    // Handshake to the host
    ST_RESP,
    // Discard DATAx then NAK
    ST_DROP,
    // Endpoint data routed to the encoder
    ST_SEND,
    // Waiting for the host handshake or a timeout
    ST_WAIT
  } xact_state_t;

  // Encoder multiplexer select
  typedef enum logic [2:0] {
    EP_IDX_CTRL = 3'd0,
    EP_IDX_OUT  = 3'd1,
    EP_IDX_IN   = 3'd2,
    EP_IDX_NONE = 3'd7
  } ep_idx_t;

endpackage

// File: hw/usb_xact_config.svh
`ifndef USB_XACT_CONFIG_SVH
`define USB_XACT_CONFIG_SVH

// Endpoint numbers of the two bulk endpoints
`define USB_BULK_OUT_EP 4'd1
`define USB_BULK_IN_EP 4'd2

// Device address width
`define USB_ADDR_W 7

// Protocol timer limits, in clock cycles
// Bus turnaround after sending DATAx
`define USB_TA_CYCLES 102
// Endpoint start of DATAx after an IN token
`define USB_EP_CYCLES 24
// Start of DATAx after an OUT or SETUP token
`define USB_TD_CYCLES 24

`endif
